//--- Bender.yml
package:
  name: sorcerer_display

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/sorcerer_pkg.sv
      - rtl/raster_timing.sv
      - rtl/byte_ram.sv
      - rtl/char_pipeline.sv
      - rtl/key_matrix.sv
      - rtl/host_port.sv
      - rtl/sorcerer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_sorcerer.sv

//--- bench/tb_sorcerer.sv
`timescale 1ns/1ps
`include "sorcerer_defs.svh"

module tb_sorcerer;

    import sorcerer_pkg::*;

    localparam int     LINE_CLKS    = 2 * `LINE_TICKS;   // Two clocks per pixel tick
    localparam longint FRAME_MAX    = longint'(`LINES_PAL) * LINE_CLKS;
    localparam int     TEXT_ROWS    = 30;                // 240 active lines of 8
    localparam int     ACTIVE_LINES = TEXT_ROWS * 8;
    localparam int     HBLANK_CLKS  = LINE_CLKS - 8 * `CHARS_PER_LINE;  // 8 clocks per character
    localparam int     KEY_STEPS    = 200;
    localparam longint KBD_CLKS     = KEY_STEPS * 12 + 16 * 8 + 24 * 4 + 2 * (2048 + 16);
    // About 3 NTSC, 4 PAL and 6 pixel-test frames, with margin
    localparam longint WATCHDOG_NS  = (16 * FRAME_MAX + KBD_CLKS) * 4;

    logic       CLK12;
    logic       RESET;
    addr_t      bus_addr;
    byte_t      bus_wdata;
    logic       bus_wr;
    logic       bus_io;
    logic       bus_rd;
    byte_t      bus_rdata;
    logic       key_strobe;
    logic       key_pressed;
    logic       key_extended;
    byte_t      key_code;
    logic       pal;
    logic       HSYNC;
    logic       VSYNC;
    logic       HBLANK;
    logic       VBLANK;
    logic       VIDEO;
    logic       UPCASE;

    key_cols_t   model_rows [16];   // Key model, active low
    logic [31:0] rng_state;
    longint      cyc = 0;
    longint      hblank_clks;       // Blanking clocks seen by the last wait
    longint      vblank_clks;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed = 0;

    sorcerer_top sorcerer_top_inst (
        .CLK12        (CLK12),
        .RESET        (RESET),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .bus_wr       (bus_wr),
        .bus_io       (bus_io),
        .bus_rd       (bus_rd),
        .bus_rdata    (bus_rdata),
        .key_strobe   (key_strobe),
        .key_pressed  (key_pressed),
        .key_extended (key_extended),
        .key_code     (key_code),
        .pal          (pal),
        .HSYNC        (HSYNC),
        .VSYNC        (VSYNC),
        .HBLANK       (HBLANK),
        .VBLANK       (VBLANK),
        .VIDEO        (VIDEO),
        .UPCASE       (UPCASE)
    );

    initial begin
        CLK12 = 1'b0;
        forever #2 CLK12 = ~CLK12;
    end

    always @(posedge CLK12) cyc <= cyc + 1;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] rand_next();
        logic [31:0] s;
        s = rng_state;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        rng_state = s;
        return s;
    endfunction

    // {code, row, column} for letters, digits and keypad
    function automatic logic [15:0] key_entry(input int idx);
        case (idx)
            0:       return 16'h1C22;
            1:       return 16'h3250;
            2:       return 16'h2130;
            3:       return 16'h2331;
            4:       return 16'h2442;
            5:       return 16'h2B40;
            6:       return 16'h3452;
            7:       return 16'h3362;
            8:       return 16'h1B32;
            9:       return 16'h1523;
            10:      return 16'h1A21;
            11:      return 16'h2220;
            12:      return 16'h1624;   // Digits
            13:      return 16'h1E34;
            14:      return 16'h2644;
            15:      return 16'h2543;
            16:      return 16'h4594;
            17:      return 16'h4683;
            18:      return 16'h70D0;   // Keypad
            19:      return 16'h69D1;
            20:      return 16'h72E1;
            21:      return 16'h74E3;
            22:      return 16'h7AF4;
            default: return 16'h79C0;
        endcase
    endfunction

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_cols(input string name, input key_cols_t got, input key_cols_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input longint got, input longint exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic bus_write(input addr_t addr, input byte_t data, input logic io);
        @(posedge CLK12);
        bus_addr  <= addr;
        bus_wdata <= data;
        bus_io    <= io;
        bus_rd    <= 1'b0;
        bus_wr    <= 1'b1;
    endtask

    task automatic bus_idle();
        @(posedge CLK12);
        bus_wr <= 1'b0;
        bus_rd <= 1'b0;
        bus_io <= 1'b0;
    endtask

    // Read data is combinational, sampled mid-cycle with VBLANK
    task automatic port_read(output byte_t data, output logic vb);
        @(posedge CLK12);
        bus_addr <= {8'h00, `KBD_PORT};
        bus_io   <= 1'b1;
        bus_wr   <= 1'b0;
        bus_rd   <= 1'b1;
        @(negedge CLK12);
        data = bus_rdata;
        vb   = VBLANK;
        bus_idle();
    endtask

    task automatic send_key(input byte_t code, input logic press);
        @(posedge CLK12);
        key_strobe   <= 1'b1;
        key_code     <= code;
        key_pressed  <= press;
        key_extended <= 1'b0;
        @(posedge CLK12);
        key_strobe <= 1'b0;   // Matrix takes it on this edge
    endtask

    // Waits for a rising VSYNC or HSYNC, counting VIDEO and blanking clocks meanwhile
    task automatic wait_rise(input logic on_vsync, output longint when, output longint ones);
        logic   prev;
        logic   cur;
        longint waited;
        prev        = on_vsync ? VSYNC : HSYNC;
        waited      = 0;
        ones        = 0;
        hblank_clks = 0;
        vblank_clks = 0;
        when        = cyc;
        forever begin
            @(negedge CLK12);
            cur = on_vsync ? VSYNC : HSYNC;
            if (VIDEO === 1'b1)
                ones++;
            if (HBLANK === 1'b1)
                hblank_clks++;
            if (VBLANK === 1'b1)
                vblank_clks++;
            if (cur === 1'b1 && prev === 1'b0) begin
                when = cyc;
                return;
            end
            prev = cur;
            waited++;
            if (waited > 2 * FRAME_MAX) begin
                errors++;
                $display("%s did not rise within two frames", on_vsync ? "VSYNC" : "HSYNC");
                return;
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        byte_t       rdata;
        logic        vb;
        logic [15:0] entry;
        logic [31:0] rnd;
        logic        lock;
        byte_t       code;
        byte_t       glyph [8];
        longint      t0;
        longint      t1;
        longint      ones;
        longint      pop;
        int          first;

        RESET        = 1'b1;
        bus_addr     = '0;
        bus_wdata    = '0;
        bus_wr       = 1'b0;
        bus_io       = 1'b0;
        bus_rd       = 1'b0;
        key_strobe   = 1'b0;
        key_pressed  = 1'b0;
        key_extended = 1'b0;
        key_code     = '0;
        pal          = 1'b0;
        rng_state    = 32'hd1008d51;
        for (int r = 0; r < 16; r++)
            model_rows[r] = '1;
        repeat (5) @(posedge CLK12);
        RESET <= 1'b0;

        first = errors;
        for (int r = 0; r < 16; r++) begin
            bus_write({8'h00, `KBD_PORT}, byte_t'(r), 1'b1);
            port_read(rdata, vb);
            check_byte("bus_rdata", rdata, {2'b11, vb, 5'b11111});
        end
        check_level("UPCASE", UPCASE, 1'b0);
        end_test("reset_state", first);

        first = errors;
        for (int i = 0; i < KEY_STEPS; i++) begin
            entry = key_entry(int'(rand_next() % 24));
            rnd   = rand_next();
            send_key(entry[15:8], rnd[31]);
            model_rows[entry[7:4]][entry[2:0]] = ~rnd[31];
            // Upper address and data bits are don't-care for the port
            bus_write({rnd[23:16], `KBD_PORT}, rnd[7:0], 1'b1);
            port_read(rdata, vb);
            check_byte("bus_rdata", rdata, {2'b11, vb, model_rows[rnd[3:0]]});
            check_cols("bus_rdata[4:0]", rdata[4:0], model_rows[rnd[3:0]]);
        end
        end_test("random_keys", first);

        first = errors;
        lock  = 1'b0;
        for (int i = 0; i < 6; i++) begin
            send_key(8'h58, 1'b1);
            lock = ~lock;
            @(negedge CLK12);
            check_level("UPCASE", UPCASE, lock);
            send_key(8'h58, 1'b0);   // Release leaves it alone
            @(negedge CLK12);
            check_level("UPCASE", UPCASE, lock);
        end
        end_test("shift_lock", first);

        first = errors;
        wait_rise(1'b1, t0, ones);
        wait_rise(1'b1, t1, ones);
        check_count("VSYNC period", t1 - t0, longint'(`LINES_NTSC) * LINE_CLKS);
        check_count("VBLANK high clocks", vblank_clks,
                    longint'(`LINES_NTSC - ACTIVE_LINES) * LINE_CLKS);
        check_count("HBLANK high clocks", hblank_clks, longint'(`LINES_NTSC) * HBLANK_CLKS);
        wait_rise(1'b0, t0, ones);
        wait_rise(1'b0, t1, ones);
        check_count("HSYNC period", t1 - t0, LINE_CLKS);
        @(posedge CLK12);
        pal <= 1'b1;
        wait_rise(1'b1, t0, ones);   // Frame around the switch
        wait_rise(1'b1, t0, ones);
        wait_rise(1'b1, t1, ones);
        check_count("VSYNC period", t1 - t0, longint'(`LINES_PAL) * LINE_CLKS);
        check_count("VBLANK high clocks", vblank_clks,
                    longint'(`LINES_PAL - ACTIVE_LINES) * LINE_CLKS);
        check_count("HBLANK high clocks", hblank_clks, longint'(`LINES_PAL) * HBLANK_CLKS);
        wait_rise(1'b0, t0, ones);
        wait_rise(1'b0, t1, ones);
        check_count("HSYNC period", t1 - t0, LINE_CLKS);
        end_test("sync_timing", first);

        first = errors;
        rnd   = rand_next();
        code  = rnd[7:0];
        for (int pass = 0; pass < 2; pass++) begin
            pop = 0;
            for (int r = 0; r < 8; r++) begin
                rnd      = rand_next();
                glyph[r] = (pass == 0) ? rnd[7:0] : 8'h00;
                pop      = pop + $countones(glyph[r]);
            end
            if (pass == 0) begin
                for (int a = 0; a < 2 ** `VRAM_AW; a++)
                    bus_write(addr_t'(`VRAM_BASE + a), code, 1'b0);
            end
            for (int r = 0; r < 8; r++)
                bus_write(addr_t'(`CHARGEN_BASE + code * 8 + r), glyph[r], 1'b0);
            bus_idle();
            wait_rise(1'b1, t0, ones);
            wait_rise(1'b1, t1, ones);
            check_count("VIDEO high clocks", ones, TEXT_ROWS * `CHARS_PER_LINE * pop);
        end
        end_test("char_pixels", first);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- include/sorcerer_defs.svh
`ifndef SORCERER_DEFS_SVH
`define SORCERER_DEFS_SVH

// --------------------
// Host bus map
// --------------------
`define VRAM_BASE       16'hF000    // Text screen, 64 codes per row
`define VRAM_AW         11
`define CHARGEN_BASE    16'hF800    // 256 glyphs, 8 rows each
`define CHARGEN_AW      11

`define KBD_PORT        8'hFE       // Row select out, columns in

// --------------------
// Raster counters
// --------------------
`define H_RELOAD_ACTIVE 9'd364      // Value after the last active pixel
`define V_RELOAD_NTSC   9'd491      // 21 blanking lines
`define V_RELOAD_PAL    9'd439      // 73 blanking lines
`define V_FIRST_ACTIVE  9'd16

// Display geometry
`define CHARS_PER_LINE  64
`define LINE_TICKS      404
`define LINES_NTSC      261
`define LINES_PAL       313

`endif

//--- list.f
+incdir+include
rtl/sorcerer_pkg.sv
rtl/raster_timing.sv
rtl/byte_ram.sv
rtl/char_pipeline.sv
rtl/key_matrix.sv
rtl/host_port.sv
rtl/sorcerer_top.sv
bench/tb_sorcerer.sv

//--- rtl/byte_ram.sv
`timescale 1ns/1ps

module byte_ram #(
    parameter int ADDR_W = 11
) (
    input  logic                clk12,
    input  logic                wr_en,
    input  logic [ADDR_W-1:0]   wr_addr,
    input  sorcerer_pkg::byte_t wr_data,
    input  logic [ADDR_W-1:0]   rd_addr,
    output sorcerer_pkg::byte_t rd_data
);

    import sorcerer_pkg::*;

    byte_t mem [2**ADDR_W];

    always_ff @(posedge clk12) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];  // Old data on a collision
    end

endmodule

//--- rtl/char_pipeline.sv
`timescale 1ns/1ps
`include "sorcerer_defs.svh"

module char_pipeline (
    input  logic                  clk12,
    input  logic                  reset,
    input  logic                  pix_en,
    input  logic                  load_tick,
    input  sorcerer_pkg::hcount_t hcount,
    input  sorcerer_pkg::vcount_t vcount,
    input  logic                  hblank,
    input  logic                  vblank,
    input  logic                  vram_wr,
    input  logic                  chargen_wr,
    input  logic [`VRAM_AW-1:0]   wr_offset,
    input  sorcerer_pkg::byte_t   wr_data,
    output logic                  video
);

    import sorcerer_pkg::*;

    byte_t vram_q;
    byte_t glyph_q;
    byte_t code_q;   // Current character code
    byte_t shifter;

    wire load = pix_en & load_tick;

    // Text row and column, then glyph row within the cell
    wire [`VRAM_AW-1:0]    text_addr  = {vcount[7:3], hcount[7:2]};
    wire [`CHARGEN_AW-1:0] glyph_addr = {code_q, vcount[2:0]};

    byte_ram #(.ADDR_W(`VRAM_AW)) vram_inst (
        .clk12   (clk12),
        .wr_en   (vram_wr),
        .wr_addr (wr_offset),
        .wr_data (wr_data),
        .rd_addr (text_addr),
        .rd_data (vram_q)
    );

    byte_ram #(.ADDR_W(`CHARGEN_AW)) chargen_inst (
        .clk12   (clk12),
        .wr_en   (chargen_wr),
        .wr_addr (wr_offset),
        .wr_data (wr_data),
        .rd_addr (glyph_addr),
        .rd_data (glyph_q)
    );

    always_ff @(posedge clk12) begin
        if (load)
            code_q <= vram_q;
    end

    // Eight pixels per load, MSB first at 12 MHz
    always_ff @(posedge clk12) begin
        if (reset)
            shifter <= '0;
        else if (load && !hblank && !vblank)
            shifter <= glyph_q;
        else
            shifter <= {shifter[6:0], 1'b0};
    end

    assign video = shifter[7];

endmodule

//--- rtl/host_port.sv
`timescale 1ns/1ps
`include "sorcerer_defs.svh"

module host_port (
    input  logic                    clk12,
    input  logic                    reset,
    input  sorcerer_pkg::addr_t     bus_addr,
    input  sorcerer_pkg::byte_t     bus_wdata,
    input  logic                    bus_wr,
    input  logic                    bus_io,
    input  logic                    bus_rd,
    input  sorcerer_pkg::key_cols_t row_cols,
    input  logic                    vblank,
    output sorcerer_pkg::byte_t     bus_rdata,
    output sorcerer_pkg::row_sel_t  row_sel,
    output logic                    vram_wr,
    output logic                    chargen_wr,
    output logic [`VRAM_AW-1:0]     wr_offset,
    output sorcerer_pkg::byte_t     wr_data
);

    import sorcerer_pkg::*;

    byte_t port_q;  // Serial and baud bits kept in the top nibble

    wire mem_wr  = bus_wr & ~bus_io;
    wire kbd_sel = bus_io & (bus_addr[7:0] == `KBD_PORT);

    // --------------------
    // Memory windows
    // --------------------
    assign vram_wr    = mem_wr & ((bus_addr >> `VRAM_AW) == (`VRAM_BASE >> `VRAM_AW));
    assign chargen_wr = mem_wr &
                        ((bus_addr >> `CHARGEN_AW) == (`CHARGEN_BASE >> `CHARGEN_AW));
    assign wr_offset  = bus_addr[`VRAM_AW-1:0];
    assign wr_data    = bus_wdata;

    always_ff @(posedge clk12) begin
        if (reset)
            port_q <= '0;
        else if (kbd_sel && bus_wr)
            port_q <= bus_wdata;
    end

    assign row_sel   = port_q[3:0];
    assign bus_rdata = (kbd_sel && bus_rd) ? {2'b11, vblank, row_cols} : 8'hFF;

endmodule

//--- rtl/key_matrix.sv
`timescale 1ns/1ps

module key_matrix (
    input  logic                     clk12,
    input  logic                     reset,
    input  logic                     key_strobe,
    input  logic                     key_pressed,
    input  sorcerer_pkg::scan_code_t key_code,
    input  sorcerer_pkg::row_sel_t   row_sel,
    output sorcerer_pkg::key_cols_t  row_cols,
    output logic                     upcase
);

    import sorcerer_pkg::*;

    key_cols_t matrix [16];
    logic      key_hit;
    logic [6:0] key_loc;   // {row, column}

    wire row_sel_t   key_row  = key_loc[6:3];
    wire logic [2:0] key_col  = key_loc[2:0];
    wire             lock_key = (key_code[7:0] == 8'h58);

    // --------------------
    // PS/2 code to matrix position
    // --------------------
    always_comb begin
        key_hit = 1'b1;
        key_loc = '0;
        casez (key_code)
            9'h171: key_loc = {4'd0, 3'd0};   // Del as STOP
            9'h011: key_loc = {4'd0, 3'd1};   // Left Alt as GRAPHICS
            9'h?14: key_loc = {4'd0, 3'd2};
            9'h?58: key_loc = {4'd0, 3'd3};   // Shift lock
            9'h?12: key_loc = {4'd0, 3'd4};
            9'h?59: key_loc = {4'd0, 3'd4};
            9'h16C: key_loc = {4'd1, 3'd0};   // Home as CLEAR
            9'h111: key_loc = {4'd1, 3'd1};   // Right Alt as REPEAT
            9'h?29: key_loc = {4'd1, 3'd2};
            9'h?0D: key_loc = {4'd1, 3'd3};   // Tab as SKIP
            9'h?76: key_loc = {4'd1, 3'd4};
            9'h?22: key_loc = {4'd2, 3'd0};
            9'h?1A: key_loc = {4'd2, 3'd1};
            9'h?1C: key_loc = {4'd2, 3'd2};
            9'h?15: key_loc = {4'd2, 3'd3};
            9'h?16: key_loc = {4'd2, 3'd4};
            9'h?21: key_loc = {4'd3, 3'd0};
            9'h?23: key_loc = {4'd3, 3'd1};
            9'h?1B: key_loc = {4'd3, 3'd2};
            9'h?1D: key_loc = {4'd3, 3'd3};
            9'h?1E: key_loc = {4'd3, 3'd4};
            9'h?2B: key_loc = {4'd4, 3'd0};
            9'h?2D: key_loc = {4'd4, 3'd1};
            9'h?24: key_loc = {4'd4, 3'd2};
            9'h?25: key_loc = {4'd4, 3'd3};
            9'h?26: key_loc = {4'd4, 3'd4};
            9'h?32: key_loc = {4'd5, 3'd0};
            9'h?2A: key_loc = {4'd5, 3'd1};
            9'h?34: key_loc = {4'd5, 3'd2};
            9'h?2C: key_loc = {4'd5, 3'd3};
            9'h?2E: key_loc = {4'd5, 3'd4};
            9'h?3A: key_loc = {4'd6, 3'd0};
            9'h?31: key_loc = {4'd6, 3'd1};
            9'h?33: key_loc = {4'd6, 3'd2};
            9'h?35: key_loc = {4'd6, 3'd3};
            9'h?36: key_loc = {4'd6, 3'd4};
            9'h?42: key_loc = {4'd7, 3'd0};
            9'h?43: key_loc = {4'd7, 3'd1};
            9'h?3B: key_loc = {4'd7, 3'd2};
            9'h?3C: key_loc = {4'd7, 3'd3};
            9'h?3D: key_loc = {4'd7, 3'd4};
            9'h?41: key_loc = {4'd8, 3'd0};
            9'h?4B: key_loc = {4'd8, 3'd1};
            9'h?44: key_loc = {4'd8, 3'd2};
            9'h?46: key_loc = {4'd8, 3'd3};
            9'h?3E: key_loc = {4'd8, 3'd4};
            9'h04A: key_loc = {4'd9, 3'd0};   // Slash, main block only
            9'h?49: key_loc = {4'd9, 3'd1};
            9'h?4C: key_loc = {4'd9, 3'd2};
            9'h?4D: key_loc = {4'd9, 3'd3};
            9'h?45: key_loc = {4'd9, 3'd4};
            9'h?5D: key_loc = {4'd10, 3'd0};
            9'h?52: key_loc = {4'd10, 3'd1};  // Quote as @
            9'h?5B: key_loc = {4'd10, 3'd2};
            9'h?54: key_loc = {4'd10, 3'd3};
            9'h?0E: key_loc = {4'd10, 3'd4};  // Backtick as colon
            9'h?66: key_loc = {4'd11, 3'd0};
            9'h?5A: key_loc = {4'd11, 3'd1};  // Both Enter keys
            9'h17D: key_loc = {4'd11, 3'd2};  // PgUp
            9'h?55: key_loc = {4'd11, 3'd3};
            9'h?4E: key_loc = {4'd11, 3'd4};
            // Keypad
            9'h079: key_loc = {4'd12, 3'd0};
            9'h07C: key_loc = {4'd12, 3'd1};
            9'h14A: key_loc = {4'd12, 3'd2};
            9'h07B: key_loc = {4'd12, 3'd3};
            9'h070: key_loc = {4'd13, 3'd0};
            9'h069: key_loc = {4'd13, 3'd1};
            9'h06B: key_loc = {4'd13, 3'd2};
            9'h075: key_loc = {4'd13, 3'd3};
            9'h06C: key_loc = {4'd13, 3'd4};
            9'h071: key_loc = {4'd14, 3'd0};
            9'h072: key_loc = {4'd14, 3'd1};
            9'h073: key_loc = {4'd14, 3'd2};
            9'h074: key_loc = {4'd14, 3'd3};
            9'h07D: key_loc = {4'd14, 3'd4};
            9'h07A: key_loc = {4'd15, 3'd4};
            default: key_hit = 1'b0;
        endcase
    end

    // --------------------
    // Matrix storage
    // --------------------
    always_ff @(posedge clk12) begin
        if (reset) begin
            for (int i = 0; i < 16; i++)
                matrix[i] <= '1;
        end else if (key_strobe && key_hit) begin
            if (lock_key) begin
                if (key_pressed)
                    matrix[0][3] <= ~matrix[0][3];  // Toggle, release ignored
            end else begin
                matrix[key_row][key_col] <= ~key_pressed;
            end
        end
    end

    assign row_cols = matrix[row_sel];
    assign upcase   = ~matrix[0][3];

endmodule

//--- rtl/raster_timing.sv
`timescale 1ns/1ps
`include "sorcerer_defs.svh"

module raster_timing (
    input  logic                  clk12,
    input  logic                  reset,
    input  logic                  pal,
    output logic                  pix_en,
    output sorcerer_pkg::hcount_t hcount,
    output sorcerer_pkg::vcount_t vcount,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  hblank,
    output logic                  vblank,
    output logic                  load_tick
);

    logic pal_q;      // Standard in use for the current frame
    logic hblank_q;

    wire line_end  = pix_en & (&hcount);
    wire frame_end = line_end & (&vcount);
    wire load      = pix_en & load_tick;

    // --------------------
    // Counters
    // --------------------
    always_ff @(posedge clk12) begin
        if (reset) begin
            pix_en <= 1'b0;
            hcount <= '0;
            vcount <= `V_FIRST_ACTIVE;
            pal_q  <= 1'b0;
        end else begin
            pix_en <= ~pix_en;  // 6 MHz pixel tick
            if (pix_en) begin
                if (&hcount[7:0])
                    hcount <= hcount[8] ? 9'd0 : `H_RELOAD_ACTIVE;
                else
                    hcount <= hcount + 9'd1;
            end
            if (line_end) begin
                if (&vcount[7:0])
                    vcount <= vcount[8] ? `V_FIRST_ACTIVE :
                              (pal_q ? `V_RELOAD_PAL : `V_RELOAD_NTSC);
                else
                    vcount <= vcount + 9'd1;
            end
            if (frame_end)
                pal_q <= pal;
        end
    end

    // --------------------
    // Sync and blanking
    // --------------------
    always_ff @(posedge clk12) begin
        if (reset) begin
            vsync    <= 1'b0;
            hblank_q <= 1'b1;   // Same as at the start of a line
            hblank   <= 1'b1;
        end else begin
            if (line_end)
                vsync <= vcount[8] & ~vcount[4] & vcount[3];  // Sync band
            if (!vcount[5])
                vsync <= 1'b0;
            // Two loads of delay to line up with the shifter
            if (load) begin
                hblank_q <= hcount[8];
                hblank   <= hblank_q;
            end
        end
    end

    assign hsync     = hcount[8] & hcount[5] & ~hcount[6];
    assign vblank    = vcount[8];
    assign load_tick = &hcount[1:0];  // One pixel tick in four

endmodule

//--- rtl/sorcerer_pkg.sv
package sorcerer_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;       // Host bus address

    // Raster counters, bit 8 set during blanking
    typedef logic [8:0]  hcount_t;
    typedef logic [8:0]  vcount_t;

    // Keyboard
    typedef logic [3:0]  row_sel_t;
    typedef logic [4:0]  key_cols_t;   // Active low
    typedef logic [8:0]  scan_code_t;  // Extended flag in bit 8

endpackage

//--- rtl/sorcerer_top.sv
`timescale 1ns/1ps
`include "sorcerer_defs.svh"

module sorcerer_top (
    input  logic                CLK12,
    input  logic                RESET,
    input  sorcerer_pkg::addr_t bus_addr,
    input  sorcerer_pkg::byte_t bus_wdata,
    input  logic                bus_wr,
    input  logic                bus_io,
    input  logic                bus_rd,
    output sorcerer_pkg::byte_t bus_rdata,
    input  logic                key_strobe,
    input  logic                key_pressed,
    input  logic                key_extended,
    input  sorcerer_pkg::byte_t key_code,
    input  logic                pal,
    output logic                HSYNC,
    output logic                VSYNC,
    output logic                HBLANK,
    output logic                VBLANK,
    output logic                VIDEO,
    output logic                UPCASE
);

    import sorcerer_pkg::*;

    logic                pix_en;
    logic                load_tick;
    hcount_t             hcount;
    vcount_t             vcount;
    row_sel_t            row_sel;
    key_cols_t           row_cols;
    logic                vram_wr;
    logic                chargen_wr;
    logic [`VRAM_AW-1:0] wr_offset;
    byte_t               wr_data;

    raster_timing raster_timing_inst (
        .clk12     (CLK12),
        .reset     (RESET),
        .pal       (pal),
        .pix_en    (pix_en),
        .hcount    (hcount),
        .vcount    (vcount),
        .hsync     (HSYNC),
        .vsync     (VSYNC),
        .hblank    (HBLANK),
        .vblank    (VBLANK),
        .load_tick (load_tick)
    );

    char_pipeline char_pipeline_inst (
        .clk12      (CLK12),
        .reset      (RESET),
        .pix_en     (pix_en),
        .load_tick  (load_tick),
        .hcount     (hcount),
        .vcount     (vcount),
        .hblank     (HBLANK),
        .vblank     (VBLANK),
        .vram_wr    (vram_wr),
        .chargen_wr (chargen_wr),
        .wr_offset  (wr_offset),
        .wr_data    (wr_data),
        .video      (VIDEO)
    );

    key_matrix key_matrix_inst (
        .clk12       (CLK12),
        .reset       (RESET),
        .key_strobe  (key_strobe),
        .key_pressed (key_pressed),
        .key_code    ({key_extended, key_code}),  // Extended flag on top
        .row_sel     (row_sel),
        .row_cols    (row_cols),
        .upcase      (UPCASE)
    );

    host_port host_port_inst (
        .clk12      (CLK12),
        .reset      (RESET),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_io     (bus_io),
        .bus_rd     (bus_rd),
        .row_cols   (row_cols),
        .vblank     (VBLANK),
        .bus_rdata  (bus_rdata),
        .row_sel    (row_sel),
        .vram_wr    (vram_wr),
        .chargen_wr (chargen_wr),
        .wr_offset  (wr_offset),
        .wr_data    (wr_data)
    );

endmodule
